//--- tests/ciStimulus.txt
01 12345678 00000000 78563412 1
01 12345678 00000001 34127856 1
01 deadbeef 00000000 efbeadde 1
01 deadbeef 00000001 addeefbe 1
01 a5c3e10f fffffffe 0fe1c3a5 1
09 0000f800 00000000 00000034 1
09 000007e0 00000000 000000b4 1
09 0000ffff 00000000 000000fa 1
09 00000000 00000000 00000000 1
09 abcd001f 00000000 00000012 1
06 00000000 00000000 00000000 1
06 00000001 00000000 00000000 1
06 00000005 00000000 00000000 1
03 00000000 00000000 00000000 1
0c 00000000 00000004 00000000 0
0c 00000000 00000000 00000000 1
0c 00000000 00000001 00000000 0
06 00000002 00000000 00000000 1
0c 00000000 00000002 00000000 0
0c 00000000 00000000 00000000 0
0c 00000000 00000000 00000000 2
0c 00000000 00000004 00000000 2
0c 00000000 00000000 00000000 1
ff 12345678 00000001 00000000 1
00 ffffffff ffffffff 00000000 1

//--- all.f
source/ciPackage.sv
source/resetSequencer.sv
source/ciDecode.sv
source/ciPixelOps.sv
source/ciDelay.sv
source/ciProfiler.sv
source/ciResultCombine.sv
source/ciTop.sv
tests/ciTop_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --assert -Wno-fatal -j 0
TOP ?= ciTop_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT = Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/ciTop_tb.sv
`timescale 1ns/100ps

module ciTop_tb;

  import ciPackage::*;

  localparam int cyclesPerMicrosecond = 4;
  localparam int resetCycles = 16;  // Five-bit sequencer counter
  localparam int resetTimeout = 100;
  localparam int doneTimeout = 400;
  localparam string stimulusPath = "tests/ciStimulus.txt";

  logic s_systemClock;
  logic s_pllLocked;
  logic ciStart;
  ciId ciN;
  ciWord ciDataA;
  ciWord ciDataB;
  logic ciDone;
  ciWord ciResult;
  logic resetDone;

  int checkCount;
  int mismatchCount;
  int failureCount;
  int timeoutCount;
  int linesRead;
  ciWord lastResult;

  ciTop #(
    .cyclesPerMicrosecond(cyclesPerMicrosecond)
  ) dut_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .ciDone(ciDone),
    .ciResult(ciResult),
    .resetDone(resetDone)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #5 s_systemClock = ~s_systemClock;
  end

  // PLL low for 8 cycles, then lock; a ciStart in either phase must stay unanswered
  task automatic releaseReset();
    int cycles;
    cycles = 0;
    for (int i = 0; i < 8; i++) begin
      @(posedge s_systemClock);
      ciN <= 8'h01;
      ciDataA <= 32'h12345678;
      ciStart <= (i == 4);
      @(negedge s_systemClock);
      checkCount++;
      assert (!ciDone) else begin
        failureCount++;
        $display("ciDone pulsed at %0t while the PLL was still unlocked", $time);
      end
      checkCount++;
      assert (!resetDone) else begin
        mismatchCount++;
        $display("mismatch at %0t: resetDone expected 0, got %b", $time, resetDone);
      end
    end
    @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    while (!resetDone && cycles < resetTimeout) begin
      @(posedge s_systemClock);
      cycles++;
      ciStart <= (cycles == 3);  // Start inside the reset window
      @(negedge s_systemClock);
      checkCount++;
      assert (!ciDone) else begin
        failureCount++;
        $display("ciDone pulsed at %0t while the processor was still in reset", $time);
      end
    end
    if (!resetDone) begin
      timeoutCount++;
      $display("timeout at %0t: resetDone stayed low for %0d cycles after PLL lock",
               $time, resetTimeout);
    end else begin
      checkCount++;
      assert (cycles == resetCycles) else begin
        mismatchCount++;
        $display("mismatch at %0t: resetDone cycles expected %0d, got %0d",
                 $time, resetCycles, cycles);
      end
    end
  endtask

  // Flag 0 ignores the result, 1 compares it, 2 wants the previous answer again and nonzero
  task automatic runInstruction(input ciId id, input ciWord a, input ciWord b,
                                input ciWord expected, input int flag);
    int latency;
    int wantLatency;
    logic seen;
    latency = 0;
    seen = 1'b0;
    if (id == 8'h06 && a != '0) begin
      wantLatency = int'(a) * cyclesPerMicrosecond + 1;
    end else begin
      wantLatency = 1;
    end
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN <= id;
    ciDataA <= a;
    ciDataB <= b;
    while (!seen && latency < doneTimeout) begin
      @(posedge s_systemClock);
      ciStart <= 1'b0;
      latency++;
      @(negedge s_systemClock);
      seen = ciDone;
    end
    if (!seen) begin
      timeoutCount++;
      $display("timeout at %0t: no ciDone within %0d cycles for instruction %h",
               $time, doneTimeout, id);
    end else begin
      checkCount++;
      assert (latency == wantLatency) else begin
        mismatchCount++;
        $display("mismatch at %0t: ciDone latency expected %0d, got %0d",
                 $time, wantLatency, latency);
      end
      if (flag == 1) begin
        checkCount++;
        assert (ciResult == expected) else begin
          mismatchCount++;
          $display("mismatch at %0t: ciResult expected %h, got %h", $time, expected, ciResult);
        end
      end else if (flag == 2) begin
        checkCount++;
        assert (ciResult == lastResult) else begin
          mismatchCount++;
          $display("mismatch at %0t: ciResult expected %h, got %h",
                   $time, lastResult, ciResult);
        end
        checkCount++;
        assert (ciResult != '0) else begin
          failureCount++;
          $display("profiler returned zero at %0t although it had been running", $time);
        end
      end
      lastResult = ciResult;
      @(posedge s_systemClock);
      @(negedge s_systemClock);
      checkCount++;
      assert (!ciDone && ciResult == '0) else begin
        failureCount++;
        $display("answer at %0t lasted longer than one cycle", $time);
      end
    end
  endtask

  task automatic playStimulus();
    int fd;
    int fields;
    int flag;
    ciId id;
    ciWord a;
    ciWord b;
    ciWord expected;
    fd = $fopen(stimulusPath, "r");
    if (fd == 0) begin
      failureCount++;
      $display("could not open the stimulus file %s", stimulusPath);
    end else begin
      fields = $fscanf(fd, " %h %h %h %h %d", id, a, b, expected, flag);
      while (fields == 5 && timeoutCount == 0) begin
        linesRead++;
        runInstruction(id, a, b, expected, flag);
        fields = $fscanf(fd, " %h %h %h %h %d", id, a, b, expected, flag);
      end
      $fclose(fd);
      if (linesRead == 0) begin
        failureCount++;
        $display("no instruction lines were read from %s", stimulusPath);
      end
    end
  endtask

  initial begin
    s_pllLocked = 1'b0;
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    checkCount = 0;
    mismatchCount = 0;
    failureCount = 0;
    timeoutCount = 0;
    linesRead = 0;
    lastResult = '0;
    releaseReset();
    if (timeoutCount == 0) begin
      playStimulus();
    end
    repeat (3) @(posedge s_systemClock);
    $display("%0d lines, %0d checks, %0d mismatches, %0d other failures, %0d timeouts",
             linesRead, checkCount, mismatchCount, failureCount, timeoutCount);
    if (mismatchCount == 0 && failureCount == 0 && timeoutCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- source/ciTop.sv
`timescale 1ns/100ps

module ciTop #(
  parameter int cyclesPerMicrosecond = 74,
  parameter int resetCountWidth = 5
) (
  input  logic            s_systemClock,
  input  logic            s_pllLocked,
  input  logic            ciStart,
  input  ciPackage::ciId   ciN,
  input  ciPackage::ciWord ciDataA,
  input  ciPackage::ciWord ciDataB,
  output logic            ciDone,
  output ciPackage::ciWord ciResult,
  output logic            resetDone
);

  import ciPackage::*;

  logic cpuReset;
  logic swapSel;
  logic graySel;
  logic delaySel;
  logic profileSel;
  logic unknownDone;
  logic pixelDone;
  logic delayDone;
  logic profileDone;
  ciWord pixelResult;
  ciWord delayResult;
  ciWord profileResult;

  resetSequencer #(
    .resetCountWidth(resetCountWidth)
  ) sequencer (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .cpuReset(cpuReset),
    .resetDone(resetDone)
  );

  ciDecode decoder (
    .s_systemClock(s_systemClock),
    .cpuReset(cpuReset),
    .ciStart(ciStart),
    .ciN(ciN),
    .swapSel(swapSel),
    .graySel(graySel),
    .delaySel(delaySel),
    .profileSel(profileSel),
    .unknownDone(unknownDone)
  );

  ciPixelOps pixelOps (
    .s_systemClock(s_systemClock),
    .cpuReset(cpuReset),
    .swapSel(swapSel),
    .graySel(graySel),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .pixelDone(pixelDone),
    .pixelResult(pixelResult)
  );

  ciDelay #(
    .cyclesPerMicrosecond(cyclesPerMicrosecond)
  ) delayMicro (
    .s_systemClock(s_systemClock),
    .cpuReset(cpuReset),
    .delaySel(delaySel),
    .ciDataA(ciDataA),
    .delayDone(delayDone),
    .delayResult(delayResult)
  );

  ciProfiler profiler (
    .s_systemClock(s_systemClock),
    .cpuReset(cpuReset),
    .profileSel(profileSel),
    .ciDataB(ciDataB),
    .profileDone(profileDone),
    .profileResult(profileResult)
  );

  ciResultCombine combine (
    .s_systemClock(s_systemClock),
    .cpuReset(cpuReset),
    .pixelDone(pixelDone),
    .delayDone(delayDone),
    .profileDone(profileDone),
    .unknownDone(unknownDone),
    .pixelResult(pixelResult),
    .delayResult(delayResult),
    .profileResult(profileResult),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

endmodule

//--- source/ciResultCombine.sv
`timescale 1ns/100ps

module ciResultCombine (
  input  logic            s_systemClock,
  input  logic            cpuReset,
  input  logic            pixelDone,
  input  logic            delayDone,
  input  logic            profileDone,
  input  logic            unknownDone,
  input  ciPackage::ciWord pixelResult,
  input  ciPackage::ciWord delayResult,
  input  ciPackage::ciWord profileResult,
  output logic            ciDone,
  output ciPackage::ciWord ciResult
);

  import ciPackage::*;

  logic mergedDone;
  ciWord mergedResult;

  // Idle units drive zero, so a plain OR merges them
  assign mergedDone = pixelDone | delayDone | profileDone | unknownDone;
  assign mergedResult = pixelResult | delayResult | profileResult;

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      ciDone <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone <= mergedDone;
      ciResult <= mergedResult;
    end
  end

endmodule

//--- source/ciProfiler.sv
`timescale 1ns/100ps

module ciProfiler (
  input  logic            s_systemClock,
  input  logic            cpuReset,
  input  logic            profileSel,
  input  ciPackage::ciWord ciDataB,
  output logic            profileDone,
  output ciPackage::ciWord profileResult
);

  import ciPackage::*;

  ciWord cycleCount;
  logic running;
  logic startCmd;
  logic stopCmd;
  logic clearCmd;

  assign startCmd = profileSel & ciDataB[profileStartBit];
  assign stopCmd = profileSel & ciDataB[profileStopBit];
  assign clearCmd = profileSel & ciDataB[profileClearBit];

  // Start wins when both control bits are set
  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      running <= 1'b0;
    end else if (startCmd) begin
      running <= 1'b1;
    end else if (stopCmd) begin
      running <= 1'b0;
    end
  end

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      cycleCount <= '0;
    end else if (clearCmd) begin
      cycleCount <= '0;
    end else if (running) begin
      cycleCount <= cycleCount + 1'b1;
    end
  end

  assign profileDone = profileSel;

  // Value before any clear of this instruction
  assign profileResult = profileSel ? cycleCount : '0;

endmodule

//--- source/ciDelay.sv
`timescale 1ns/100ps

module ciDelay #(
  parameter int cyclesPerMicrosecond = 74
) (
  input  logic            s_systemClock,
  input  logic            cpuReset,
  input  logic            delaySel,
  input  ciPackage::ciWord ciDataA,
  output logic            delayDone,
  output ciPackage::ciWord delayResult
);

  import ciPackage::*;

  localparam int prescaleWidth =
    (cyclesPerMicrosecond > 1) ? $clog2(cyclesPerMicrosecond) : 1;
  localparam logic [prescaleWidth-1:0] prescaleLoad =
    prescaleWidth'(cyclesPerMicrosecond - 1);

  delayState stateReg;
  ciWord microsecondsLeft;
  logic [prescaleWidth-1:0] prescaleCount;
  logic zeroDelay;
  logic countEnd;

  assign zeroDelay = delaySel && (ciDataA == '0);  // Answered at once
  assign countEnd = (stateReg == delayCounting) && (prescaleCount == '0)
                    && (microsecondsLeft == ciWord'(1));

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      stateReg <= delayIdle;
      microsecondsLeft <= '0;
      prescaleCount <= '0;
    end else begin
      case (stateReg)
        delayIdle: begin
          if (delaySel && !zeroDelay) begin
            stateReg <= delayCounting;
            microsecondsLeft <= ciDataA;
            prescaleCount <= prescaleLoad;
          end
        end
        delayCounting: begin
          if (prescaleCount != '0) begin
            prescaleCount <= prescaleCount - 1'b1;
          end else if (countEnd) begin
            stateReg <= delayIdle;
          end else begin
            microsecondsLeft <= microsecondsLeft - 1'b1;  // Next microsecond
            prescaleCount <= prescaleLoad;
          end
        end
        default: stateReg <= delayIdle;
      endcase
    end
  end

  assign delayDone = zeroDelay | countEnd;
  assign delayResult = '0;

endmodule

//--- source/ciPixelOps.sv
`timescale 1ns/100ps

module ciPixelOps (
  input  logic            s_systemClock,
  input  logic            cpuReset,
  input  logic            swapSel,
  input  logic            graySel,
  input  ciPackage::ciWord ciDataA,
  input  ciPackage::ciWord ciDataB,
  output logic            pixelDone,
  output ciPackage::ciWord pixelResult
);

  import ciPackage::*;

  logic pixelSel;
  logic servedLast;
  ciWord swapValue;
  ciWord grayValue;
  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;
  logic [15:0] graySum;

  assign pixelSel = swapSel | graySel;

  // Remembers a served strobe so a held strobe answers once
  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      servedLast <= 1'b0;
    end else begin
      servedLast <= pixelSel;
    end
  end

  always_comb begin
    if (ciDataB[0]) begin
      swapValue = {ciDataA[23:16], ciDataA[31:24], ciDataA[7:0], ciDataA[15:8]};
    end else begin
      swapValue = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};
    end
  end

  // RGB565 widened to 8 bits per channel
  assign red = {ciDataA[15:11], 3'b000};
  assign green = {ciDataA[10:5], 2'b00};
  assign blue = {ciDataA[4:0], 3'b000};

  assign graySum = 16'd54 * red + 16'd183 * green + 16'd19 * blue;  // Peak sum fits 16 bits
  assign grayValue = {24'd0, graySum[15:8]};

  assign pixelDone = pixelSel & ~servedLast;

  always_comb begin
    if (!pixelDone) begin
      pixelResult = '0;
    end else if (swapSel) begin
      pixelResult = swapValue;
    end else begin
      pixelResult = grayValue;
    end
  end

endmodule

//--- source/ciDecode.sv
`timescale 1ns/100ps

module ciDecode (
  input  logic          s_systemClock,
  input  logic          cpuReset,
  input  logic          ciStart,
  input  ciPackage::ciId ciN,
  output logic          swapSel,
  output logic          graySel,
  output logic          delaySel,
  output logic          profileSel,
  output logic          unknownDone
);

  import ciPackage::*;

  logic startArmed;
  logic startAccepted;

  // Opens one cycle after the processor leaves reset
  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      startArmed <= 1'b0;
    end else begin
      startArmed <= 1'b1;
    end
  end

  assign startAccepted = ciStart & startArmed;

  always_comb begin
    swapSel = 1'b0;
    graySel = 1'b0;
    delaySel = 1'b0;
    profileSel = 1'b0;
    unknownDone = 1'b0;
    if (startAccepted) begin
      case (ciN)
        ciSwapByte:  swapSel = 1'b1;
        ciGrayscale: graySel = 1'b1;
        ciDelay:     delaySel = 1'b1;
        ciProfile:   profileSel = 1'b1;
        default:     unknownDone = 1'b1;  // Answer with zero, never hang
      endcase
    end
  end

endmodule

//--- source/resetSequencer.sv
`timescale 1ns/100ps

module resetSequencer #(
  parameter int resetCountWidth = 5
) (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset,
  output logic resetDone
);

  logic [resetCountWidth-1:0] resetCount;
  logic countDone;

  assign countDone = resetCount[resetCountWidth-1];  // Top bit ends the sequence

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!countDone) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign cpuReset = ~countDone;
  assign resetDone = countDone;

endmodule

//--- source/ciPackage.sv
package ciPackage;

  localparam int ciWordWidth = 32;
  localparam int ciIdWidth = 8;

  typedef logic [ciWordWidth-1:0] ciWord;
  typedef logic [ciIdWidth-1:0] ciId;

  // Custom instruction numbers served by this engine
  typedef enum logic [ciIdWidth-1:0] {
    ciSwapByte  = 8'd1,
    ciDelay     = 8'd6,
    ciGrayscale = 8'd9,
    ciProfile   = 8'd12
  } ciOpcode;

  typedef enum logic {
    delayIdle,
    delayCounting
  } delayState;

  // Profiler control bits in operand B
  localparam int profileStartBit = 0;
  localparam int profileStopBit = 1;
  localparam int profileClearBit = 2;

endpackage
